// ==== design/hpm_pkg.sv ====
// Performance monitor package with sizes, functional units, event codes and the APB register map
`default_nettype none

package hpm_pkg;

  // Sizes
  localparam int NUM_COUNTERS = 4;
  localparam int NUM_COMMIT   = 2;
  localparam int CNT_W        = 64;
  localparam int DATA_W       = 32;                     // APB data width
  localparam int ADDR_W       = 12;                     // APB byte offset width
  localparam int EVSEL_W      = 5;
  localparam int CNT_IDX_W    = $clog2(NUM_COUNTERS);   // Counter index on the write strobe

  // Functional unit of a retiring instruction
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_LOAD  = 3'd1,
    FU_STORE = 3'd2,
    FU_CTRL  = 3'd3,
    FU_ALU   = 3'd4,
    FU_MULT  = 3'd5,
    FU_FPU   = 3'd6
  } fu_e;

  // Event selector codes, anything above EV_STALL counts nothing
  localparam logic [EVSEL_W-1:0] EV_NONE        = 5'd0;
  localparam logic [EVSEL_W-1:0] EV_ICACHE_MISS = 5'd1;
  localparam logic [EVSEL_W-1:0] EV_DCACHE_MISS = 5'd2;
  localparam logic [EVSEL_W-1:0] EV_ITLB_MISS   = 5'd3;
  localparam logic [EVSEL_W-1:0] EV_DTLB_MISS   = 5'd4;
  localparam logic [EVSEL_W-1:0] EV_LOAD        = 5'd5;
  localparam logic [EVSEL_W-1:0] EV_STORE       = 5'd6;
  localparam logic [EVSEL_W-1:0] EV_EXCEPTION   = 5'd7;
  localparam logic [EVSEL_W-1:0] EV_ERET        = 5'd8;
  localparam logic [EVSEL_W-1:0] EV_BRANCH      = 5'd9;
  localparam logic [EVSEL_W-1:0] EV_MISPREDICT  = 5'd10;
  localparam logic [EVSEL_W-1:0] EV_INT         = 5'd11;  // ALU or multiplier
  localparam logic [EVSEL_W-1:0] EV_FP          = 5'd12;
  localparam logic [EVSEL_W-1:0] EV_STALL       = 5'd13;

  // Register map, byte offsets
  localparam logic [ADDR_W-1:0] CNT_LO_BASE  = 12'h000;  // Counter k low half at +8k
  localparam logic [ADDR_W-1:0] CNT_HI_BASE  = 12'h004;  // Counter k high half at +8k
  localparam logic [ADDR_W-1:0] EVSEL_BASE   = 12'h040;  // Selector k at +4k
  localparam logic [ADDR_W-1:0] INHIBIT_ADDR = 12'h060;

endpackage

`default_nettype wire

// ==== design/commit_event_decode.sv ====
// Commit event decoder, classifies retiring instructions per port and merges them into class flags
`timescale 1ns/10ps
`default_nettype none

module commit_event_decode (
  input  logic [hpm_pkg::NUM_COMMIT-1:0]             commit_ack_i,
  input  hpm_pkg::fu_e [hpm_pkg::NUM_COMMIT-1:0]     commit_fu_i,
  output logic                                       load_ev_o,
  output logic                                       store_ev_o,
  output logic                                       branch_ev_o,
  output logic                                       int_ev_o,
  output logic                                       fp_ev_o
);
  import hpm_pkg::*;

  fu_e [NUM_COMMIT-1:0]  ret_fu;   // Unit of the instruction actually retiring
  logic [NUM_COMMIT-1:0] load_port;
  logic [NUM_COMMIT-1:0] store_port;
  logic [NUM_COMMIT-1:0] branch_port;
  logic [NUM_COMMIT-1:0] int_port;
  logic [NUM_COMMIT-1:0] fp_port;

  // No acknowledge means nothing retires on that port
  always_comb begin
    for (int p = 0; p < NUM_COMMIT; p++) begin
      ret_fu[p] = commit_ack_i[p] ? commit_fu_i[p] : FU_NONE;
    end
  end

  always_comb begin : classify
    for (int p = 0; p < NUM_COMMIT; p++) begin
      load_port[p]   = (ret_fu[p] == FU_LOAD);
      store_port[p]  = (ret_fu[p] == FU_STORE);
      branch_port[p] = (ret_fu[p] == FU_CTRL);
      int_port[p]    = (ret_fu[p] == FU_ALU) || (ret_fu[p] == FU_MULT);
      fp_port[p]     = (ret_fu[p] == FU_FPU);
    end
  end

  // Two ports of one class in a cycle still give a single event
  assign load_ev_o   = |load_port;
  assign store_ev_o  = |store_port;
  assign branch_ev_o = |branch_port;
  assign int_ev_o    = |int_port;
  assign fp_ev_o     = |fp_port;

endmodule

`default_nettype wire

// ==== design/hpm_apb_regs.sv ====
// APB register block of the performance monitor, holds selectors and inhibit and decodes counter access
`timescale 1ns/10ps
`default_nettype none

module hpm_apb_regs (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic [hpm_pkg::ADDR_W-1:0]                                paddr_i,
  input  logic                                                      psel_i,
  input  logic                                                      penable_i,
  input  logic                                                      pwrite_i,
  input  logic [hpm_pkg::DATA_W-1:0]                                pwdata_i,
  input  logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::CNT_W-1:0]      cnt_val_i,
  output logic [hpm_pkg::DATA_W-1:0]                                prdata_o,
  output logic                                                      pready_o,
  output logic                                                      pslverr_o,
  output logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::EVSEL_W-1:0]    evsel_o,
  output logic [hpm_pkg::NUM_COUNTERS-1:0]                          inhibit_o,
  output logic                                                      cnt_we_o,
  output logic [hpm_pkg::CNT_IDX_W-1:0]                             cnt_idx_o,
  output logic                                                      cnt_hi_o,
  output logic [hpm_pkg::DATA_W-1:0]                                cnt_wdata_o
);
  import hpm_pkg::*;

  logic                               access;
  logic                               wr_en;
  logic                               rd_en;
  logic                               hit_cnt_lo;
  logic                               hit_cnt_hi;
  logic                               hit_evsel;
  logic                               hit_inhibit;
  logic                               hit_any;
  logic [CNT_IDX_W-1:0]               hit_idx;     // Counter or selector addressed
  logic [NUM_COUNTERS-1:0][EVSEL_W-1:0] evsel_q;
  logic [NUM_COUNTERS-1:0]            inhibit_q;

  // Access phase, no wait states
  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i;
  assign rd_en  = access && !pwrite_i;

  always_comb begin : addr_decode
    hit_cnt_lo  = 1'b0;
    hit_cnt_hi  = 1'b0;
    hit_evsel   = 1'b0;
    hit_idx     = '0;
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      if (paddr_i == CNT_LO_BASE + ADDR_W'(8 * k)) begin
        hit_cnt_lo = 1'b1;
        hit_idx    = CNT_IDX_W'(k);
      end
      if (paddr_i == CNT_HI_BASE + ADDR_W'(8 * k)) begin
        hit_cnt_hi = 1'b1;
        hit_idx    = CNT_IDX_W'(k);
      end
      if (paddr_i == EVSEL_BASE + ADDR_W'(4 * k)) begin
        hit_evsel = 1'b1;
        hit_idx   = CNT_IDX_W'(k);
      end
    end
    hit_inhibit = (paddr_i == INHIBIT_ADDR);
  end

  assign hit_any   = hit_cnt_lo || hit_cnt_hi || hit_evsel || hit_inhibit;
  assign pready_o  = 1'b1;
  assign pslverr_o = access && !hit_any;  // Unmapped offset

  // Counter writes go to the bank as a one-cycle strobe
  assign cnt_we_o    = wr_en && (hit_cnt_lo || hit_cnt_hi);
  assign cnt_idx_o   = hit_idx;
  assign cnt_hi_o    = hit_cnt_hi;
  assign cnt_wdata_o = pwdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evsel_q   <= '0;
      inhibit_q <= '0;
    end else begin
      if (wr_en && hit_evsel) begin
        evsel_q[hit_idx] <= pwdata_i[EVSEL_W-1:0];
      end
      if (wr_en && hit_inhibit) begin
        inhibit_q <= pwdata_i[NUM_COUNTERS-1:0];
      end
    end
  end

  assign evsel_o   = evsel_q;
  assign inhibit_o = inhibit_q;

  // Read mux, zero outside a read access phase
  always_comb begin : read_mux
    prdata_o = '0;
    if (rd_en) begin
      if (hit_cnt_lo) begin
        prdata_o = cnt_val_i[hit_idx][DATA_W-1:0];
      end else if (hit_cnt_hi) begin
        prdata_o = cnt_val_i[hit_idx][CNT_W-1:DATA_W];
      end else if (hit_evsel) begin
        prdata_o = DATA_W'(evsel_q[hit_idx]);
      end else if (hit_inhibit) begin
        prdata_o = DATA_W'(inhibit_q);
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/hpm_counter_bank.sv ====
// Counter bank with per-counter event selection, gated increment and software half writes
`timescale 1ns/10ps
`default_nettype none

module hpm_counter_bank (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    debug_mode_i,
  input  logic                                                    icache_miss_i,
  input  logic                                                    dcache_miss_i,
  input  logic                                                    itlb_miss_i,
  input  logic                                                    dtlb_miss_i,
  input  logic                                                    exception_i,
  input  logic                                                    eret_i,
  input  logic                                                    mispredict_i,
  input  logic                                                    stall_issue_i,
  input  logic                                                    load_ev_i,
  input  logic                                                    store_ev_i,
  input  logic                                                    branch_ev_i,
  input  logic                                                    int_ev_i,
  input  logic                                                    fp_ev_i,
  input  logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::EVSEL_W-1:0]  evsel_i,
  input  logic [hpm_pkg::NUM_COUNTERS-1:0]                        inhibit_i,
  input  logic                                                    cnt_we_i,
  input  logic [hpm_pkg::CNT_IDX_W-1:0]                           cnt_idx_i,
  input  logic                                                    cnt_hi_i,
  input  logic [hpm_pkg::DATA_W-1:0]                              cnt_wdata_i,
  output logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::CNT_W-1:0]    cnt_val_o
);
  import hpm_pkg::*;

  logic [NUM_COUNTERS-1:0]            cnt_event;
  logic [NUM_COUNTERS-1:0]            cnt_inc;
  logic [NUM_COUNTERS-1:0][CNT_W-1:0] cnt_d;
  logic [NUM_COUNTERS-1:0][CNT_W-1:0] cnt_q;

  // Event select per counter
  always_comb begin : event_mux
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      case (evsel_i[k])
        EV_NONE:        cnt_event[k] = 1'b0;
        EV_ICACHE_MISS: cnt_event[k] = icache_miss_i;
        EV_DCACHE_MISS: cnt_event[k] = dcache_miss_i;
        EV_ITLB_MISS:   cnt_event[k] = itlb_miss_i;
        EV_DTLB_MISS:   cnt_event[k] = dtlb_miss_i;
        EV_LOAD:        cnt_event[k] = load_ev_i;
        EV_STORE:       cnt_event[k] = store_ev_i;
        EV_EXCEPTION:   cnt_event[k] = exception_i;
        EV_ERET:        cnt_event[k] = eret_i;
        EV_BRANCH:      cnt_event[k] = branch_ev_i;
        EV_MISPREDICT:  cnt_event[k] = mispredict_i;
        EV_INT:         cnt_event[k] = int_ev_i;
        EV_FP:          cnt_event[k] = fp_ev_i;
        EV_STALL:       cnt_event[k] = stall_issue_i;
        default:        cnt_event[k] = 1'b0;  // Reserved codes
      endcase
    end
  end

  // Frozen in debug mode or when inhibited
  assign cnt_inc = cnt_event & ~inhibit_i & {NUM_COUNTERS{!debug_mode_i}};

  always_comb begin : next_value
    cnt_d = cnt_q;
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      // A software write takes priority and drops that cycle's increment
      if (cnt_we_i && (cnt_idx_i == CNT_IDX_W'(k))) begin
        if (cnt_hi_i) begin
          cnt_d[k][CNT_W-1:DATA_W] = cnt_wdata_i;
        end else begin
          cnt_d[k][DATA_W-1:0] = cnt_wdata_i;
        end
      end else if (cnt_inc[k]) begin
        cnt_d[k] = cnt_q[k] + CNT_W'(1);  // Full 64-bit add, low half carries up
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_val_o = cnt_q;

endmodule

`default_nettype wire

// ==== design/hpm_unit.sv ====
// Performance monitor top level joining commit decoder, APB registers and counter bank
`timescale 1ns/10ps
`default_nettype none

module hpm_unit (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // APB slave
  input  logic [hpm_pkg::ADDR_W-1:0]                  paddr_i,
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [hpm_pkg::DATA_W-1:0]                  pwdata_i,
  output logic [hpm_pkg::DATA_W-1:0]                  prdata_o,
  output logic                                        pready_o,
  output logic                                        pslverr_o,
  // Event pulses
  input  logic                                        icache_miss_i,
  input  logic                                        dcache_miss_i,
  input  logic                                        itlb_miss_i,
  input  logic                                        dtlb_miss_i,
  input  logic                                        exception_i,
  input  logic                                        eret_i,
  input  logic                                        mispredict_i,
  input  logic                                        stall_issue_i,
  input  logic [hpm_pkg::NUM_COMMIT-1:0]              commit_ack_i,
  input  hpm_pkg::fu_e [hpm_pkg::NUM_COMMIT-1:0]      commit_fu_i,
  input  logic                                        debug_mode_i
);
  import hpm_pkg::*;

  logic                                 load_ev;
  logic                                 store_ev;
  logic                                 branch_ev;
  logic                                 int_ev;
  logic                                 fp_ev;
  logic [NUM_COUNTERS-1:0][EVSEL_W-1:0] evsel;
  logic [NUM_COUNTERS-1:0]              inhibit;
  logic                                 cnt_we;
  logic [CNT_IDX_W-1:0]                 cnt_idx;
  logic                                 cnt_hi;
  logic [DATA_W-1:0]                    cnt_wdata;
  logic [NUM_COUNTERS-1:0][CNT_W-1:0]   cnt_val;

  commit_event_decode u_commit_decode (
    .commit_ack_i (commit_ack_i),
    .commit_fu_i  (commit_fu_i),
    .load_ev_o    (load_ev),
    .store_ev_o   (store_ev),
    .branch_ev_o  (branch_ev),
    .int_ev_o     (int_ev),
    .fp_ev_o      (fp_ev)
  );

  hpm_apb_regs u_apb_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .cnt_val_i   (cnt_val),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .evsel_o     (evsel),
    .inhibit_o   (inhibit),
    .cnt_we_o    (cnt_we),
    .cnt_idx_o   (cnt_idx),
    .cnt_hi_o    (cnt_hi),
    .cnt_wdata_o (cnt_wdata)
  );

  hpm_counter_bank u_counter_bank (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .debug_mode_i  (debug_mode_i),
    .icache_miss_i (icache_miss_i),
    .dcache_miss_i (dcache_miss_i),
    .itlb_miss_i   (itlb_miss_i),
    .dtlb_miss_i   (dtlb_miss_i),
    .exception_i   (exception_i),
    .eret_i        (eret_i),
    .mispredict_i  (mispredict_i),
    .stall_issue_i (stall_issue_i),
    .load_ev_i     (load_ev),
    .store_ev_i    (store_ev),
    .branch_ev_i   (branch_ev),
    .int_ev_i      (int_ev),
    .fp_ev_i       (fp_ev),
    .evsel_i       (evsel),
    .inhibit_i     (inhibit),
    .cnt_we_i      (cnt_we),
    .cnt_idx_i     (cnt_idx),
    .cnt_hi_i      (cnt_hi),
    .cnt_wdata_i   (cnt_wdata),
    .cnt_val_o     (cnt_val)
  );

endmodule

`default_nettype wire

// ==== bench/hpm_checker.sv ====
// Counter bank checker with concurrent assertions on debug freeze, software writes and idle counters
`timescale 1ns/10ps
`default_nettype none

module hpm_checker (
  input logic                                                    clk_i,
  input logic                                                    rst_ni,
  input logic                                                    debug_mode_i,
  input logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::EVSEL_W-1:0]  evsel_i,
  input logic                                                    cnt_we_i,
  input logic [hpm_pkg::CNT_IDX_W-1:0]                           cnt_idx_i,
  input logic                                                    cnt_hi_i,
  input logic [hpm_pkg::DATA_W-1:0]                              cnt_wdata_i,
  input logic [hpm_pkg::NUM_COUNTERS-1:0][hpm_pkg::CNT_W-1:0]    cnt_val_i
);
  import hpm_pkg::*;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  for (genvar k = 0; k < NUM_COUNTERS; k++) begin : g_cnt
    logic own_we;  // Software write to this counter
    assign own_we = cnt_we_i && (cnt_idx_i == CNT_IDX_W'(k));

    debug_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        debug_mode_i && !own_we |=> $stable(cnt_val_i[k]))
      else begin
        fail_cnt++;
        $error("counter %0d changed during debug mode", k);
      end

    // Written half holds the bus data one cycle later
    write_lands: assert property (@(posedge clk_i) disable iff (!rst_ni)
        own_we |=> (($past(cnt_hi_i) ? cnt_val_i[k][CNT_W-1:DATA_W]
                                     : cnt_val_i[k][DATA_W-1:0]) == $past(cnt_wdata_i)))
      else begin
        fail_cnt++;
        $error("counter %0d half differs from written data", k);
      end

    idle_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (evsel_i[k] == EV_NONE) && !own_we |=> $stable(cnt_val_i[k]))
      else begin
        fail_cnt++;
        $error("counter %0d with no event selected changed", k);
      end
  end

endmodule

bind hpm_counter_bank hpm_checker u_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .debug_mode_i (debug_mode_i),
  .evsel_i      (evsel_i),
  .cnt_we_i     (cnt_we_i),
  .cnt_idx_i    (cnt_idx_i),
  .cnt_hi_i     (cnt_hi_i),
  .cnt_wdata_i  (cnt_wdata_i),
  .cnt_val_i    (cnt_val_o)
);

`default_nettype wire

// ==== bench/hpm_tb.sv ====
// Performance monitor testbench with APB driver, random events and a reference counter model
`timescale 1ns/10ps
`default_nettype none

module hpm_tb;
  import hpm_pkg::*;

  localparam int WAIT_MAX = 16;  // Cycles to wait for pready

  logic                    clk_i;
  logic                    rst_ni;
  logic [ADDR_W-1:0]       paddr_i;
  logic                    psel_i;
  logic                    penable_i;
  logic                    pwrite_i;
  logic [DATA_W-1:0]       pwdata_i;
  logic [DATA_W-1:0]       prdata_o;
  logic                    pready_o;
  logic                    pslverr_o;
  logic                    icache_miss_i;
  logic                    dcache_miss_i;
  logic                    itlb_miss_i;
  logic                    dtlb_miss_i;
  logic                    exception_i;
  logic                    eret_i;
  logic                    mispredict_i;
  logic                    stall_issue_i;
  logic [NUM_COMMIT-1:0]   commit_ack_i;
  fu_e [NUM_COMMIT-1:0]    commit_fu_i;
  logic                    debug_mode_i;

  logic [CNT_W-1:0]        cnt_model [NUM_COUNTERS];
  logic [EVSEL_W-1:0]      sel_model [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] inh_model;
  logic [31:0]             rng;
  int                      errors;
  int                      timeouts;

  hpm_unit dut_i (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Any acknowledged port whose unit lies in first..last
  function automatic logic class_hit(input fu_e first, input fu_e last);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < NUM_COMMIT; p++) begin
      if (commit_ack_i[p] && commit_fu_i[p] >= first && commit_fu_i[p] <= last) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic event_fired(input logic [EVSEL_W-1:0] code);
    case (code)
      EV_ICACHE_MISS: return icache_miss_i;
      EV_DCACHE_MISS: return dcache_miss_i;
      EV_ITLB_MISS:   return itlb_miss_i;
      EV_DTLB_MISS:   return dtlb_miss_i;
      EV_LOAD:        return class_hit(FU_LOAD, FU_LOAD);
      EV_STORE:       return class_hit(FU_STORE, FU_STORE);
      EV_EXCEPTION:   return exception_i;
      EV_ERET:        return eret_i;
      EV_BRANCH:      return class_hit(FU_CTRL, FU_CTRL);
      EV_MISPREDICT:  return mispredict_i;
      EV_INT:         return class_hit(FU_ALU, FU_MULT);
      EV_FP:          return class_hit(FU_FPU, FU_FPU);
      EV_STALL:       return stall_issue_i;
      default:        return 1'b0;
    endcase
  endfunction

  // 0 unmapped, 1 counter low, 2 counter high, 3 selector, 4 inhibit
  function automatic int map_kind(input logic [ADDR_W-1:0] a);
    if (a[1:0] != 2'b00) return 0;
    if (a < 12'h020) return a[2] ? 2 : 1;  // Four counters of 8 bytes
    if (a >= EVSEL_BASE && a < EVSEL_BASE + 12'h010) return 3;
    if (a == INHIBIT_ADDR) return 4;
    return 0;
  endfunction

  function automatic logic [DATA_W-1:0] expected_rdata(input logic [ADDR_W-1:0] a);
    case (map_kind(a))
      1:       return cnt_model[a[4:3]][DATA_W-1:0];
      2:       return cnt_model[a[4:3]][CNT_W-1:DATA_W];
      3:       return {27'd0, sel_model[a[3:2]]};
      4:       return {28'd0, inh_model};
      default: return 32'd0;
    endcase
  endfunction

  // Reference counters follow the bus and event inputs seen at each edge
  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    int   kind;
    logic wr;
    kind = map_kind(paddr_i);
    wr   = psel_i && penable_i && pwrite_i;
    if (!rst_ni) begin
      for (int k = 0; k < NUM_COUNTERS; k++) begin
        cnt_model[k] = '0;
        sel_model[k] = '0;
      end
      inh_model = '0;
    end else begin
      for (int k = 0; k < NUM_COUNTERS; k++) begin
        if (wr && (kind == 1 || kind == 2) && int'(paddr_i[4:3]) == k) begin
          if (kind == 2) cnt_model[k][CNT_W-1:DATA_W] = pwdata_i;
          else cnt_model[k][DATA_W-1:0] = pwdata_i;
        end else if (event_fired(sel_model[k]) && !inh_model[k] && !debug_mode_i) begin
          cnt_model[k] = cnt_model[k] + 64'd1;
        end
      end
      if (wr && kind == 3) sel_model[paddr_i[3:2]] = pwdata_i[EVSEL_W-1:0];
      if (wr && kind == 4) inh_model = pwdata_i[NUM_COUNTERS-1:0];
    end
  end

  task automatic idle_inputs();
    {icache_miss_i, dcache_miss_i, itlb_miss_i, dtlb_miss_i} <= 4'b0;
    {exception_i, eret_i, mispredict_i, stall_issue_i} <= 4'b0;
    commit_ack_i    <= '0;
    commit_fu_i[0]  <= FU_NONE;
    commit_fu_i[1]  <= FU_NONE;
    debug_mode_i    <= 1'b0;
  endtask

  // One APB transfer, checks read data and slave error in the access phase
  task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
                            input logic [DATA_W-1:0] wdata);
    int                n;
    logic [DATA_W-1:0] exp;
    @(posedge clk_i);
    paddr_i   <= addr;
    pwrite_i  <= wr;
    pwdata_i  <= wdata;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!pready_o && n < WAIT_MAX);
    if (!pready_o) begin
      timeouts++;
      $display("timeout at %0t: pready never rose for offset 0x%03h", $time, addr);
    end else begin
      exp = wr ? 32'd0 : expected_rdata(addr);
      assert (prdata_o == exp) else begin
        errors++;
        $display("mismatch at %0t: offset 0x%03h read 0x%08h, expected 0x%08h",
                 $time, addr, prdata_o, exp);
      end
      assert (pslverr_o == (map_kind(addr) == 0)) else begin
        errors++;
        $display("mismatch at %0t: offset 0x%03h pslverr %0b", $time, addr, pslverr_o);
      end
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  // Codes packed as {c3, c2, c1, c0}
  task automatic select_events(input logic [4*EVSEL_W-1:0] codes);
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      apb_access(EVSEL_BASE + ADDR_W'(4 * k), 1'b1, 32'(codes[EVSEL_W*k +: EVSEL_W]));
    end
  endtask

  task automatic check_all();
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      apb_access(CNT_LO_BASE + ADDR_W'(8 * k), 1'b0, 32'd0);
      apb_access(CNT_HI_BASE + ADDR_W'(8 * k), 1'b0, 32'd0);
      apb_access(EVSEL_BASE + ADDR_W'(4 * k), 1'b0, 32'd0);
    end
    apb_access(INHIBIT_ADDR, 1'b0, 32'd0);
  endtask

  task automatic drive_random(input int cycles, input logic with_debug);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      rng = xorshift(rng);
      {icache_miss_i, dcache_miss_i, itlb_miss_i, dtlb_miss_i} <= rng[3:0];
      {exception_i, eret_i, mispredict_i, stall_issue_i} <= rng[7:4];
      commit_ack_i   <= rng[9:8];
      commit_fu_i[0] <= fu_e'((rng[12:10] == 3'd7) ? 3'd4 : rng[12:10]);
      commit_fu_i[1] <= fu_e'((rng[15:13] == 3'd7) ? 3'd4 : rng[15:13]);
      debug_mode_i   <= with_debug & rng[16] & rng[17];  // Debug about a quarter of cycles
    end
    @(posedge clk_i);
    idle_inputs();
  endtask

  initial begin : main
    int chk_fails;
    rng       = 32'hfc547fe0;
    errors    = 0;
    timeouts  = 0;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    idle_inputs();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    check_all();                                  // Reset values
    select_events({EV_STALL, EV_EXCEPTION, EV_DTLB_MISS, EV_ICACHE_MISS});
    drive_random(200, 1'b0);
    check_all();
    select_events({EV_FP, EV_INT, EV_STORE, EV_LOAD});
    drive_random(200, 1'b0);
    check_all();

    // Inhibit counters 0 and 2, debug toggles, reserved code on counter 3
    select_events({5'd31, EV_ITLB_MISS, EV_INT, EV_DCACHE_MISS});
    apb_access(INHIBIT_ADDR, 1'b1, 32'h5);
    drive_random(200, 1'b1);
    check_all();
    apb_access(INHIBIT_ADDR, 1'b1, 32'h0);
    select_events({EV_NONE, EV_MISPREDICT, EV_BRANCH, EV_ERET});  // Counter 3 idle
    drive_random(100, 1'b1);
    check_all();

    // Carry from low half into high half on counter 2
    select_events({EV_STALL, EV_EXCEPTION, EV_STORE, EV_LOAD});
    apb_access(CNT_LO_BASE + 12'h010, 1'b1, 32'hffff_ffff);
    apb_access(CNT_HI_BASE + 12'h010, 1'b1, 32'd5);
    @(posedge clk_i);
    exception_i <= 1'b1;
    @(posedge clk_i);
    exception_i <= 1'b0;
    check_all();
    exception_i <= 1'b1;                          // Still high at the write edge
    apb_access(CNT_LO_BASE + 12'h010, 1'b1, 32'h0000_1234);
    exception_i <= 1'b0;
    check_all();

    // Unmapped offsets
    apb_access(12'h070, 1'b0, 32'd0);
    apb_access(12'h070, 1'b1, 32'hffff_ffff);
    apb_access(12'h050, 1'b1, 32'h1f);
    apb_access(12'h002, 1'b0, 32'd0);
    check_all();

    chk_fails = int'(dut_i.u_counter_bank.u_checker.fail_cnt);
    $display("errors: %0d mismatches, %0d timeouts, %0d checker failures",
             errors, timeouts, chk_fails);
    if (errors == 0 && timeouts == 0 && chk_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/hpm_pkg.sv
design/commit_event_decode.sv
design/hpm_apb_regs.sv
design/hpm_counter_bank.sv
design/hpm_unit.sv
bench/hpm_checker.sv
bench/hpm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the performance monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module hpm_tb -o hpm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/hpm_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0
